/* include/radio_ctrl_consts.svh */
////////////////////////////////////////////////////////////////////////////
// Radio control constants
// Bus widths, register offsets and reset values shared by the register
// port, the clocking block and the link block
////////////////////////////////////////////////////////////////////////////

`ifndef RADIO_CTRL_CONSTS_SVH
`define RADIO_CTRL_CONSTS_SVH

`define REG_AWIDTH          16     // Register address width
`define REG_DWIDTH          32     // Register data width

`define REG_RADIO_CLK_CTRL  16'h0000
`define REG_JESD_REFCLK     16'h0004  // Read only
`define REG_MYK_RESET       16'h0008
`define REG_LINK_CTRL       16'h0010
`define REG_LINK_STATUS     16'h0014  // Write clears sync-loss count

`define CLK_EN_WIDTH        3
`define LINK_EN_WIDTH       3
`define SYNC_CNT_WIDTH      8
`define SYNC_COUNT_MAX      8'hFF  // Saturation point

`define CLK_CTRL_RESET      4'h8   // Only clock-generator reset set
`define MYK_RESET_INIT      1'b1   // Transceiver reset is active low
`define LINK_CTRL_RESET     3'b000

`endif

/* source/regport_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Register port types
// Address, data and response types for the AXI4-Lite slave bridge
////////////////////////////////////////////////////////////////////////////

`include "radio_ctrl_consts.svh"

package regport_pkg;

  typedef logic [`REG_AWIDTH-1:0] reg_addr_t;
  typedef logic [`REG_DWIDTH-1:0] reg_data_t;
  typedef logic [1:0]             axi_resp_t;

  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  // Bridge FSM
  typedef enum logic [2:0] {
    IDLE, WR_STROBE, WR_WAIT, WR_RESP, RD_STROBE, RD_WAIT, RD_RESP
  } bridge_state_t;

endpackage

/* source/radio_ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Radio control field types
// Control and status fields of the clocking and link blocks
////////////////////////////////////////////////////////////////////////////

`include "radio_ctrl_consts.svh"

package radio_ctrl_pkg;

  // Bit 0 is 1x, bit 1 is 2x, bit 2 is 3x
  typedef logic [`CLK_EN_WIDTH-1:0]   clk_enable_t;

  // Saturating count of sync losses
  typedef logic [`SYNC_CNT_WIDTH-1:0] sync_count_t;

  // Bit 0 is ADC link, bit 1 is DAC link, bit 2 is sysref
  typedef logic [`LINK_EN_WIDTH-1:0]  link_enable_t;

endpackage

/* source/axil_regport_bridge.sv */
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite to register port bridge
// Turns AXI4-Lite transactions into single-cycle read and write strobes
// and arbitrates round-robin between the read and write channels
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module axil_regport_bridge (
  input  logic                   bus_clk,
  input  logic                   bus_rst,

  input  regport_pkg::reg_addr_t s_axi_awaddr,
  input  logic                   s_axi_awvalid,
  output logic                   s_axi_awready,

  input  regport_pkg::reg_data_t s_axi_wdata,
  input  logic                   s_axi_wvalid,
  output logic                   s_axi_wready,

  output regport_pkg::axi_resp_t s_axi_bresp,
  output logic                   s_axi_bvalid,
  input  logic                   s_axi_bready,

  input  regport_pkg::reg_addr_t s_axi_araddr,
  input  logic                   s_axi_arvalid,
  output logic                   s_axi_arready,

  output regport_pkg::reg_data_t s_axi_rdata,
  output regport_pkg::axi_resp_t s_axi_rresp,
  output logic                   s_axi_rvalid,
  input  logic                   s_axi_rready,

  output logic                   reg_rd,
  output logic                   reg_wr,
  output regport_pkg::reg_addr_t reg_addr,
  output regport_pkg::reg_data_t reg_wr_data,
  input  regport_pkg::reg_data_t reg_rd_data,
  input  logic                   reg_ready
);

  regport_pkg::bridge_state_t state;
  regport_pkg::reg_addr_t     addr_q;
  regport_pkg::reg_data_t     wdata_q;
  regport_pkg::reg_data_t     rdata_q;
  logic                       last_rd;     // Last grant went to the read channel
  logic                       wr_pending;
  logic                       rd_pending;
  logic                       grant_wr;
  logic                       grant_rd;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin grant
  ////////////////////////////////////////////////////////////////////////////

  assign wr_pending = s_axi_awvalid & s_axi_wvalid;  // Needs both AW and W
  assign rd_pending = s_axi_arvalid;

  assign grant_wr = (state == regport_pkg::IDLE) & wr_pending & (~rd_pending | last_rd);
  assign grant_rd = (state == regport_pkg::IDLE) & rd_pending & (~wr_pending | ~last_rd);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      last_rd <= 1'b1;                     // Write wins first
    end else if (grant_wr | grant_rd) begin
      last_rd <= grant_rd;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transaction FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state <= regport_pkg::IDLE;
    end else begin
      case (state)
        regport_pkg::IDLE: begin
          if (grant_wr) begin
            state <= regport_pkg::WR_STROBE;
          end else if (grant_rd) begin
            state <= regport_pkg::RD_STROBE;
          end
        end
        regport_pkg::WR_STROBE: state <= regport_pkg::WR_WAIT;
        regport_pkg::WR_WAIT: begin
          if (reg_ready) state <= regport_pkg::WR_RESP;
        end
        regport_pkg::WR_RESP: begin
          if (s_axi_bready) state <= regport_pkg::IDLE;
        end
        regport_pkg::RD_STROBE: state <= regport_pkg::RD_WAIT;
        regport_pkg::RD_WAIT: begin
          if (reg_ready) state <= regport_pkg::RD_RESP;
        end
        regport_pkg::RD_RESP: begin
          if (s_axi_rready) state <= regport_pkg::IDLE;
        end
        default: state <= regport_pkg::IDLE;
      endcase
    end
  end

  // Address and data captured at the handshake
  always_ff @(posedge bus_clk) begin
    if (grant_wr) begin
      addr_q  <= s_axi_awaddr;
      wdata_q <= s_axi_wdata;
    end else if (grant_rd) begin
      addr_q  <= s_axi_araddr;
    end
    if ((state == regport_pkg::RD_WAIT) && reg_ready) begin
      rdata_q <= reg_rd_data;              // Combined read data from both blocks
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign s_axi_awready = grant_wr;         // AW and W taken together
  assign s_axi_wready  = grant_wr;
  assign s_axi_arready = grant_rd;

  assign s_axi_bvalid  = (state == regport_pkg::WR_RESP);
  assign s_axi_bresp   = regport_pkg::AXI_RESP_OKAY;
  assign s_axi_rvalid  = (state == regport_pkg::RD_RESP);
  assign s_axi_rresp   = regport_pkg::AXI_RESP_OKAY;
  assign s_axi_rdata   = rdata_q;

  assign reg_wr        = (state == regport_pkg::WR_STROBE);
  assign reg_rd        = (state == regport_pkg::RD_STROBE);
  assign reg_addr      = addr_q;
  assign reg_wr_data   = wdata_q;

endmodule

/* source/clock_ctrl_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Clocking register block
// Sample-clock enables, clock-generator reset, transceiver reset and the
// synchronized reference-clock status
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "radio_ctrl_consts.svh"

module clock_ctrl_regs (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  input  logic                      reg_rd,
  input  logic                      reg_wr,
  input  regport_pkg::reg_addr_t    reg_addr,
  input  regport_pkg::reg_data_t    reg_wr_data,
  output regport_pkg::reg_data_t    reg_rd_data,
  output logic                      reg_ready,
  input  logic                      refclk_present,
  input  logic                      radio_clks_valid,
  output radio_ctrl_pkg::clk_enable_t clk_enable,
  output logic                      mmcm_reset,
  output logic                      myk_reset_n,
  output logic                      fpga_clks_stable
);

  logic [1:0] status_meta;                 // {clks_valid, refclk}
  logic [1:0] status_sync;

  // Two-flop synchronizer for both status inputs
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      status_meta <= 2'b00;
      status_sync <= 2'b00;
    end else begin
      status_meta <= {radio_clks_valid, refclk_present};
      status_sync <= status_meta;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      {mmcm_reset, clk_enable} <= `CLK_CTRL_RESET;
      myk_reset_n              <= `MYK_RESET_INIT;
      reg_ready                <= 1'b0;
    end else begin
      reg_ready <= reg_rd | reg_wr;        // Answers every strobe
      if (reg_wr) begin
        case (reg_addr)
          `REG_RADIO_CLK_CTRL: {mmcm_reset, clk_enable} <= reg_wr_data[3:0];
          `REG_MYK_RESET:      myk_reset_n <= reg_wr_data[0];
          default: ;
        endcase
      end
    end
  end

  // Read data is zero outside our own addresses
  always_ff @(posedge bus_clk) begin
    reg_rd_data <= '0;
    if (reg_rd) begin
      case (reg_addr)
        `REG_RADIO_CLK_CTRL: reg_rd_data <= regport_pkg::reg_data_t'({mmcm_reset, clk_enable});
        `REG_JESD_REFCLK:    reg_rd_data <= regport_pkg::reg_data_t'(status_sync[0]);
        `REG_MYK_RESET:      reg_rd_data <= regport_pkg::reg_data_t'(myk_reset_n);
        default:             reg_rd_data <= '0;
      endcase
    end
  end

  assign fpga_clks_stable = status_sync[1] & clk_enable[0] & clk_enable[1];  // 1x and 2x up

endmodule

/* source/link_ctrl_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Link register block
// Link enables, synchronized ADC sync status and a saturating counter of
// sync losses while the ADC link is enabled
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "radio_ctrl_consts.svh"

module link_ctrl_regs (
  input  logic                         bus_clk,
  input  logic                         bus_rst,
  input  logic                         reg_rd,
  input  logic                         reg_wr,
  input  regport_pkg::reg_addr_t       reg_addr,
  input  regport_pkg::reg_data_t       reg_wr_data,
  output regport_pkg::reg_data_t       reg_rd_data,
  output logic                         reg_ready,
  input  logic                         adc_sync,
  output radio_ctrl_pkg::link_enable_t link_enable
);

  logic                        sync_meta;
  logic                        sync_s;     // Synchronized adc_sync
  logic                        sync_prev;
  logic                        sync_lost;
  radio_ctrl_pkg::sync_count_t sync_count;

  ////////////////////////////////////////////////////////////////////////////
  // Sync status and loss counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      sync_meta <= 1'b0;
      sync_s    <= 1'b0;
      sync_prev <= 1'b0;
    end else begin
      sync_meta <= adc_sync;
      sync_s    <= sync_meta;
      sync_prev <= sync_s;
    end
  end

  assign sync_lost = sync_prev & ~sync_s;  // Falling edge

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      sync_count <= '0;
    end else if (reg_wr && (reg_addr == `REG_LINK_STATUS)) begin
      sync_count <= '0;                    // Any write clears
    end else if (sync_lost && link_enable[0] && (sync_count != `SYNC_COUNT_MAX)) begin
      sync_count <= sync_count + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register access
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      link_enable <= `LINK_CTRL_RESET;
      reg_ready   <= 1'b0;
    end else begin
      reg_ready <= reg_rd | reg_wr;
      if (reg_wr && (reg_addr == `REG_LINK_CTRL)) begin
        link_enable <= reg_wr_data[`LINK_EN_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    reg_rd_data <= '0;
    if (reg_rd) begin
      case (reg_addr)
        `REG_LINK_CTRL:   reg_rd_data <= regport_pkg::reg_data_t'(link_enable);
        `REG_LINK_STATUS: reg_rd_data <= regport_pkg::reg_data_t'({sync_count, 7'b0, sync_s});
        default:          reg_rd_data <= '0;  // Not ours
      endcase
    end
  end

endmodule

/* source/radio_ctrl_top.sv */
////////////////////////////////////////////////////////////////////////////
// Radio control top level
// AXI4-Lite bridge driving one register port shared by the clocking
// and link register blocks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module radio_ctrl_top (
  input  logic                         bus_clk,
  input  logic                         bus_rst,

  input  regport_pkg::reg_addr_t       s_axi_awaddr,
  input  logic                         s_axi_awvalid,
  output logic                         s_axi_awready,
  input  regport_pkg::reg_data_t       s_axi_wdata,
  input  logic                         s_axi_wvalid,
  output logic                         s_axi_wready,
  output regport_pkg::axi_resp_t       s_axi_bresp,
  output logic                         s_axi_bvalid,
  input  logic                         s_axi_bready,
  input  regport_pkg::reg_addr_t       s_axi_araddr,
  input  logic                         s_axi_arvalid,
  output logic                         s_axi_arready,
  output regport_pkg::reg_data_t       s_axi_rdata,
  output regport_pkg::axi_resp_t       s_axi_rresp,
  output logic                         s_axi_rvalid,
  input  logic                         s_axi_rready,

  input  logic                         refclk_present,
  input  logic                         radio_clks_valid,
  input  logic                         adc_sync,
  output radio_ctrl_pkg::clk_enable_t  clk_enable,
  output logic                         mmcm_reset,
  output logic                         myk_reset_n,
  output logic                         fpga_clks_stable,
  output radio_ctrl_pkg::link_enable_t link_enable
);

  ////////////////////////////////////////////////////////////////////////////
  // Shared register port
  ////////////////////////////////////////////////////////////////////////////

  logic                   reg_rd;
  logic                   reg_wr;
  regport_pkg::reg_addr_t reg_addr;
  regport_pkg::reg_data_t reg_wr_data;
  regport_pkg::reg_data_t reg_rd_data;
  logic                   reg_ready;
  regport_pkg::reg_data_t clk_rd_data;
  logic                   clk_ready;
  regport_pkg::reg_data_t link_rd_data;
  logic                   link_ready;

  assign reg_rd_data = clk_rd_data | link_rd_data;  // Idle block returns zero
  assign reg_ready   = clk_ready & link_ready;

  axil_regport_bridge bridge_inst (.*);

  clock_ctrl_regs clock_regs_inst (
    .bus_clk, .bus_rst, .reg_rd, .reg_wr, .reg_addr, .reg_wr_data,
    .reg_rd_data (clk_rd_data),
    .reg_ready   (clk_ready),
    .refclk_present, .radio_clks_valid, .clk_enable, .mmcm_reset,
    .myk_reset_n, .fpga_clks_stable
  );

  link_ctrl_regs link_regs_inst (
    .bus_clk, .bus_rst, .reg_rd, .reg_wr, .reg_addr, .reg_wr_data,
    .reg_rd_data (link_rd_data),
    .reg_ready   (link_ready),
    .adc_sync, .link_enable
  );

endmodule

/* test/tb_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock generator
// Free-running bus clock
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic bus_clk
);

  initial begin
    bus_clk = 1'b0;
    forever #(PERIOD_NS / 2) bus_clk = ~bus_clk;
  end

endmodule

/* test/radio_ctrl_properties.sv */
////////////////////////////////////////////////////////////////////////////
// Radio control bus properties
// Register-port strobe rules and AXI response hold rules
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module radio_ctrl_properties (
  input logic bus_clk,
  input logic bus_rst,
  input logic reg_rd,
  input logic reg_wr,
  input logic s_axi_awready,
  input logic s_axi_wready,
  input logic s_axi_arready,
  input logic s_axi_bvalid,
  input logic s_axi_bready,
  input logic s_axi_rvalid,
  input logic s_axi_rready
);

  strobe_one_cycle: assert property (@(posedge bus_clk) disable iff (bus_rst)
    (reg_rd || reg_wr) |=> !(reg_rd || reg_wr)) else $error("strobe wider than one cycle");

  strobe_exclusive: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !(reg_rd && reg_wr)) else $error("read and write strobes together");

  bvalid_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
    (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid) else $error("bvalid dropped early");

  rvalid_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
    (s_axi_rvalid && !s_axi_rready) |=> s_axi_rvalid) else $error("rvalid dropped early");

  // First reset cycle leaves the FSM undefined, so check from the second
  quiet_in_reset: assert property (@(posedge bus_clk) (bus_rst && $past(bus_rst)) |->
    !(reg_rd || reg_wr || s_axi_awready || s_axi_wready || s_axi_arready ||
      s_axi_bvalid || s_axi_rvalid)) else $error("bus active during reset");

endmodule

/* test/radio_ctrl_top_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Radio control testbench
// AXI4-Lite stimulus against a register model of the clocking and link blocks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "radio_ctrl_consts.svh"

module radio_ctrl_top_tb;

  // Sync saturation dominates, about 270 pulses of 6 cycles plus ~80 transfers
  localparam int CYCLE_LIMIT = 4000;

  logic bus_clk, bus_rst;
  regport_pkg::reg_addr_t s_axi_awaddr, s_axi_araddr;
  regport_pkg::reg_data_t s_axi_wdata, s_axi_rdata;
  regport_pkg::axi_resp_t s_axi_bresp, s_axi_rresp;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_bvalid, s_axi_bready;
  logic s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
  logic refclk_present, radio_clks_valid, adc_sync;
  logic mmcm_reset, myk_reset_n, fpga_clks_stable;
  radio_ctrl_pkg::clk_enable_t  clk_enable;
  radio_ctrl_pkg::link_enable_t link_enable;

  integer seed = 93;
  int     errors = 0;
  int     cycles = 0;

  // Register model
  logic [3:0] exp_clk_ctrl = `CLK_CTRL_RESET;
  logic       exp_myk = 1'b1;
  logic [2:0] exp_link = 3'b000;
  logic [7:0] exp_count = 8'd0;

  tb_clock_gen #(.PERIOD_NS(20)) clk_gen_inst (.bus_clk);

  radio_ctrl_top DUT (.*);

  bind radio_ctrl_top radio_ctrl_properties props_inst (.*);

  function automatic regport_pkg::reg_data_t expected_read(regport_pkg::reg_addr_t addr);
    case (addr)
      `REG_RADIO_CLK_CTRL: return {28'd0, exp_clk_ctrl};
      `REG_JESD_REFCLK:    return {31'd0, refclk_present};
      `REG_MYK_RESET:      return {31'd0, exp_myk};
      `REG_LINK_CTRL:      return {29'd0, exp_link};
      `REG_LINK_STATUS:    return {16'd0, exp_count, 7'd0, adc_sync};
      default:             return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    check_value("clk_enable", 32'(clk_enable), 32'(exp_clk_ctrl[2:0]));
    check_value("mmcm_reset", 32'(mmcm_reset), 32'(exp_clk_ctrl[3]));
    check_value("myk_reset_n", 32'(myk_reset_n), 32'(exp_myk));
    check_value("link_enable", 32'(link_enable), 32'(exp_link));
    check_value("fpga_clks_stable", 32'(fpga_clks_stable),
                32'(radio_clks_valid & exp_clk_ctrl[0] & exp_clk_ctrl[1]));
  endtask

  // Random back-pressure before the response is taken
  task automatic stall_cycles();
    int n;
    n = {$random(seed)} % 4;
    repeat (n) @(negedge bus_clk);
  endtask

  task automatic axi_write(input regport_pkg::reg_addr_t addr, input regport_pkg::reg_data_t data);
    int n;
    @(negedge bus_clk);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    do @(posedge bus_clk); while (!s_axi_awready);
    check_value("s_axi_wready", 32'(s_axi_wready), 32'd1);  // W taken with AW
    @(negedge bus_clk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    n = 0;
    do begin
      @(posedge bus_clk);
      n++;
    end while (!s_axi_bvalid);
    check_value("write response latency", 32'(n), 32'd3);
    stall_cycles();
    @(negedge bus_clk) s_axi_bready = 1'b1;
    @(posedge bus_clk) check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'd1);
    check_value("s_axi_bresp", 32'(s_axi_bresp), 32'd0);  // OKAY
    @(negedge bus_clk) s_axi_bready = 1'b0;
    case (addr)                            // Model update, masked to defined bits
      `REG_RADIO_CLK_CTRL: exp_clk_ctrl = data[3:0];
      `REG_MYK_RESET:      exp_myk = data[0];
      `REG_LINK_CTRL:      exp_link = data[2:0];
      `REG_LINK_STATUS:    exp_count = 8'd0;
      default: ;
    endcase
  endtask

  task automatic axi_read_check(input regport_pkg::reg_addr_t addr);
    int n;
    @(negedge bus_clk);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    do @(posedge bus_clk); while (!s_axi_arready);
    @(negedge bus_clk) s_axi_arvalid = 1'b0;
    n = 0;
    do begin
      @(posedge bus_clk);
      n++;
    end while (!s_axi_rvalid);
    check_value("read response latency", 32'(n), 32'd3);
    stall_cycles();
    @(negedge bus_clk) s_axi_rready = 1'b1;
    @(posedge bus_clk);
    check_value($sformatf("s_axi_rdata[0x%04h]", addr), s_axi_rdata, expected_read(addr));
    check_value("s_axi_rresp", 32'(s_axi_rresp), 32'd0);  // OKAY
    @(negedge bus_clk) s_axi_rready = 1'b0;
  endtask

  // Write and read presented in the same cycle, responses taken at random
  task automatic write_read_same_cycle(input regport_pkg::reg_addr_t addr,
                                       input regport_pkg::reg_data_t data);
    int n = 0;
    int aw_at = 0;
    int ar_at = 0;
    bit b_done = 0;
    bit r_done = 0;
    regport_pkg::reg_data_t rd = '0;
    @(negedge bus_clk);
    s_axi_awaddr = addr;
    s_axi_wdata  = data;
    s_axi_araddr = addr;
    {s_axi_awvalid, s_axi_wvalid, s_axi_arvalid} = 3'b111;
    while (!(b_done && r_done)) begin
      s_axi_bready = 1'({$random(seed)} % 2);  // Read stays pending while B is held
      s_axi_rready = 1'({$random(seed)} % 2);
      @(posedge bus_clk);
      n++;
      if (s_axi_awvalid && s_axi_awready) aw_at = n;
      if (s_axi_arvalid && s_axi_arready) ar_at = n;
      if (s_axi_bvalid && s_axi_bready) b_done = 1;
      if (s_axi_rvalid && s_axi_rready) begin
        r_done = 1;
        rd = s_axi_rdata;
      end
      @(negedge bus_clk);
      if (aw_at != 0) {s_axi_awvalid, s_axi_wvalid} = 2'b00;
      if (ar_at != 0) s_axi_arvalid = 1'b0;
    end
    {s_axi_bready, s_axi_rready} = 2'b00;
    if (aw_at == 0 || ar_at <= aw_at) begin
      errors++;
      $display("Write was not served before the concurrent read at %0t", $time);
    end
    exp_link = data[2:0];
    check_value("s_axi_rdata after concurrent write", rd, expected_read(addr));
  endtask

  task automatic drive_sync(input logic v);
    @(negedge bus_clk);
    if (adc_sync && !v && exp_link[0] && exp_count != 8'hFF) exp_count++;
    adc_sync = v;
    repeat (2) @(negedge bus_clk);
  endtask

  task automatic set_status(input logic refclk, input logic valid);
    @(negedge bus_clk);
    refclk_present   = refclk;
    radio_clks_valid = valid;
    repeat (3) @(negedge bus_clk);
    check_outputs();
    axi_read_check(`REG_JESD_REFCLK);
  endtask

  // Timeout and response-pending monitor
  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (!bus_rst && (s_axi_bvalid || s_axi_rvalid) && (s_axi_awready || s_axi_arready)) begin
      errors++;
      $display("Handshake accepted while a response was pending at %0t", $time);
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the bus stopped responding", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    regport_pkg::reg_addr_t addr;
    regport_pkg::reg_data_t data;
    bus_rst = 1'b1;
    {s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready} = '0;
    s_axi_awaddr = '0;
    s_axi_wdata  = '0;
    s_axi_araddr = '0;
    {refclk_present, radio_clks_valid, adc_sync} = 3'b000;
    repeat (8) @(negedge bus_clk);
    bus_rst = 1'b0;

    // Reset values
    check_outputs();
    axi_read_check(`REG_RADIO_CLK_CTRL);
    axi_read_check(`REG_JESD_REFCLK);
    axi_read_check(`REG_MYK_RESET);
    axi_read_check(`REG_LINK_CTRL);
    axi_read_check(`REG_LINK_STATUS);

    // Random writes with readback
    repeat (24) begin
      case ({$random(seed)} % 3)
        0:       addr = `REG_RADIO_CLK_CTRL;
        1:       addr = `REG_MYK_RESET;
        default: addr = `REG_LINK_CTRL;
      endcase
      data = $random(seed);
      axi_write(addr, data);
      check_outputs();
      axi_read_check(addr);
    end
    axi_read_check(16'h000C);
    axi_read_check(16'h0020);
    axi_read_check(16'hFFFC);

    // Status inputs
    axi_write(`REG_RADIO_CLK_CTRL, 32'h0000_0003);
    set_status(1'b1, 1'b1);
    set_status(1'b0, 1'b1);
    set_status(1'b1, 1'b0);
    axi_write(`REG_RADIO_CLK_CTRL, 32'h0000_0001);
    set_status(1'b1, 1'b1);

    // Sync-loss counting
    axi_write(`REG_LINK_CTRL, 32'h0000_0001);
    drive_sync(1'b1);
    axi_read_check(`REG_LINK_STATUS);
    repeat (5) begin
      drive_sync(1'b0);
      drive_sync(1'b1);
    end
    drive_sync(1'b0);
    axi_read_check(`REG_LINK_STATUS);
    axi_write(`REG_LINK_CTRL, 32'h0000_0006);
    repeat (3) begin
      drive_sync(1'b1);
      drive_sync(1'b0);
    end
    axi_read_check(`REG_LINK_STATUS);
    axi_write(`REG_LINK_CTRL, 32'h0000_0001);
    repeat (260) begin
      drive_sync(1'b1);
      drive_sync(1'b0);
    end
    axi_read_check(`REG_LINK_STATUS);
    axi_write(`REG_LINK_STATUS, 32'hFFFF_FFFF);
    axi_read_check(`REG_LINK_STATUS);

    // Concurrent write and read, preceded by a read so the write wins
    axi_read_check(`REG_LINK_CTRL);
    write_read_same_cycle(`REG_LINK_CTRL, 32'h0000_0005);
    check_outputs();

    $display("Closing count: %0d errors in %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* radio_ctrl_top.f */
+incdir+include
source/regport_pkg.sv
source/radio_ctrl_pkg.sv
source/axil_regport_bridge.sv
source/clock_ctrl_regs.sv
source/link_ctrl_regs.sv
source/radio_ctrl_top.sv
test/tb_clock_gen.sv
test/radio_ctrl_properties.sv
test/radio_ctrl_top_tb.sv

/* Makefile */
# Verilator build and run of the radio control testbench

VERILATOR ?= verilator
TB_TOP    ?= radio_ctrl_top_tb
FILELIST  ?= radio_ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
